// ==== offload_cc.f ====
+incdir+src
src/offload_cc_pkg.sv
src/spill_register.sv
src/muldiv_decode.sv
src/muldiv_execute.sv
src/muldiv_result.sv
src/shared_muldiv.sv
src/offload_cc.sv
testbench/tb_offload_cc.sv

// ==== Bender.yml ====
package:
  name: offload_cc

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/offload_cc_pkg.sv
      - src/spill_register.sv
      - src/muldiv_decode.sv
      - src/muldiv_execute.sv
      - src/muldiv_result.sv
      - src/shared_muldiv.sv
      - src/offload_cc.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_offload_cc.sv

// ==== testbench/tb_offload_cc.sv ====
`timescale 1ns/1ns
`include "offload_cc_cfg.svh"

module tb_offload_cc import offload_cc_pkg::*; ();

  localparam int W              = `CC_DATA_W;
  localparam int TIMEOUT_CYCLES = 20000;

  logic      clk_i;
  logic      rst_i;
  acc_req_t  acc_qreq_i;
  logic      acc_qvalid_i;
  logic      acc_qready_o;
  acc_resp_t acc_presp_o;
  logic      acc_pvalid_o;
  logic      acc_pready_i;

  acc_resp_t   exp_q[$];
  logic [31:0] rng_state = 32'hb010d5c5;
  id_t         next_id = '0;
  int          cycle_count = 0;
  logic        q_taken;
  // 0 always ready, 1 random, 2 held low
  int          pready_mode = 0;

  offload_cc dut_i (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .acc_qreq_i   ( acc_qreq_i   ),
    .acc_qvalid_i ( acc_qvalid_i ),
    .acc_qready_o ( acc_qready_o ),
    .acc_presp_o  ( acc_presp_o  ),
    .acc_pvalid_o ( acc_pvalid_o ),
    .acc_pready_i ( acc_pready_i )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // Expected response from the M-extension rules
  function automatic acc_resp_t ref_resp(input acc_req_t req);
    acc_resp_t          resp;
    logic [2*W-1:0]     ext_a, ext_b, prod;
    logic signed [W-1:0] sa, sb, quo, rem;
    logic               div_zero, overflow;
    resp.id    = req.id;
    resp.error = 1'b0;
    resp.data  = '0;
    sa = req.arga;
    sb = req.argb;
    div_zero = (req.argb == '0);
    overflow = (req.arga == {1'b1, {(W-1){1'b0}}}) && (req.argb == '1);
    ext_a = {{W{(req.op == OP_MULH || req.op == OP_MULHSU) && req.arga[W-1]}}, req.arga};
    ext_b = {{W{(req.op == OP_MULH) && req.argb[W-1]}}, req.argb};
    // Low 2W bits of the product are exact for any operand signedness
    prod = ext_a * ext_b;
    if (!div_zero) begin
      quo = sa / sb;
      rem = sa % sb;
    end
    case (req.op)
      OP_MUL:                       resp.data = prod[W-1:0];
      OP_MULH, OP_MULHSU, OP_MULHU: resp.data = prod[2*W-1:W];
      OP_DIV: begin
        if (div_zero) resp.data = '1;
        else if (overflow) resp.data = req.arga;
        else resp.data = quo;
      end
      OP_REM: begin
        if (div_zero) resp.data = req.arga;
        else if (overflow) resp.data = '0;
        else resp.data = rem;
      end
      OP_DIVU: resp.data = div_zero ? '1 : req.arga / req.argb;
      OP_REMU: resp.data = div_zero ? req.arga : req.arga % req.argb;
      default: resp.error = 1'b1;
    endcase
    return resp;
  endfunction

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("FAILED %s: expected %h, got %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_id(input string name, input id_t exp, input id_t act);
    if (exp !== act) begin
      $display("FAILED %s: expected %h, got %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_error(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAILED %s: expected %h, got %h", name, exp, act);
      stop_run();
    end
  endtask

  // One clock step, inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk_i);
    q_taken = acc_qvalid_i && acc_qready_o;
    #1;
    case (pready_mode)
      1:       acc_pready_i = (next_rand() & 32'h3) != 0;
      2:       acc_pready_i = 1'b0;
      default: acc_pready_i = 1'b1;
    endcase
  endtask

  task automatic issue(input logic [3:0] op, input data_t a, input data_t b);
    acc_req_t req;
    req.op   = op;
    req.id   = next_id;
    req.arga = a;
    req.argb = b;
    next_id++;
    exp_q.push_back(ref_resp(req));
    acc_qreq_i   = req;
    acc_qvalid_i = 1'b1;
    q_taken      = 1'b0;
    while (!q_taken) next_cycle();
    acc_qvalid_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) next_cycle();
  endtask

  // Response monitor, pops in request order
  always @(posedge clk_i) begin : collect
    acc_resp_t exp_resp;
    if (!rst_i && acc_pvalid_o && acc_pready_i) begin
      if (exp_q.size() == 0) begin
        $display("Response arrived with no request outstanding");
        stop_run();
      end else begin
        exp_resp = exp_q.pop_front();
        check_id("acc_presp_o.id", exp_resp.id, acc_presp_o.id);
        check_data("acc_presp_o.data", exp_resp.data, acc_presp_o.data);
        check_error("acc_presp_o.error", exp_resp.error, acc_presp_o.error);
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_run();
    end
  end

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_reset();
    check_error("acc_pvalid_o", 1'b0, acc_pvalid_o);
    check_error("acc_qready_o", 1'b1, acc_qready_o);
  endtask

  task automatic test_multiply();
    for (int i = 0; i < 60; i++) begin
      issue(4'(i % 4), next_rand(), next_rand());
    end
    drain();
  endtask

  task automatic test_divide();
    data_t a, b;
    for (int i = 0; i < 60; i++) begin
      a = next_rand();
      // Vary the divisor magnitude for a spread of quotients
      b = next_rand() >> (next_rand() % W);
      issue(4'(4 + i % 4), a, b);
    end
    drain();
  endtask

  task automatic test_div_corners();
    for (int op = 4; op < 8; op++) begin
      issue(4'(op), next_rand(), '0);
      issue(4'(op), {1'b1, {(W-1){1'b0}}}, '1);
    end
    drain();
  endtask

  task automatic test_illegal_op();
    for (int op = 8; op < 16; op++) begin
      issue(4'(op), next_rand(), next_rand());
    end
    drain();
  endtask

  task automatic test_backpressure();
    pready_mode = 1;
    for (int i = 0; i < 60; i++) begin
      issue(4'(next_rand()), next_rand(), next_rand() >> (next_rand() % 8));
    end
    drain();
    // Consumer stalls with work in flight
    // Multiplies only, so all four finish inside the stall
    pready_mode = 2;
    for (int i = 0; i < 4; i++) begin
      issue(4'(next_rand() % 4), next_rand(), next_rand());
    end
    repeat (20) next_cycle();
    // Oldest response still waits at the port
    check_error("acc_pvalid_o", 1'b1, acc_pvalid_o);
    check_id("acc_presp_o.id", exp_q[0].id, acc_presp_o.id);
    pready_mode = 0;
    drain();
    // A duplicate would show up with nothing left to match
    repeat (8) next_cycle();
  endtask

  initial begin
    rst_i        = 1'b1;
    acc_qreq_i   = '0;
    acc_qvalid_i = 1'b0;
    acc_pready_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    test_reset();
    test_multiply();
    test_divide();
    test_div_corners();
    test_illegal_op();
    test_backpressure();
    if (exp_q.size() != 0) begin
      $display("%0d responses still outstanding at the end", exp_q.size());
      stop_run();
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// ==== src/offload_cc.sv ====
`timescale 1ns/1ns
`include "offload_cc_cfg.svh"

module offload_cc import offload_cc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  // Offload request from the core
  input  acc_req_t  acc_qreq_i,
  input  logic      acc_qvalid_i,
  output logic      acc_qready_o,
  // Offload response to the core
  output acc_resp_t acc_presp_o,
  output logic      acc_pvalid_o,
  input  logic      acc_pready_i
);

  acc_req_t  acc_req_q;
  logic      acc_req_q_valid, acc_req_q_ready;
  acc_resp_t acc_resp_d;
  logic      acc_resp_d_valid, acc_resp_d_ready;

  // Cut the request path
  spill_register #(
    .T      ( acc_req_t      ),
    .Bypass ( !`CC_REG_REQ   )
  ) i_spill_register_acc_req (
    .clk_i   ( clk_i           ),
    .rst_i   ( rst_i           ),
    .valid_i ( acc_qvalid_i    ),
    .ready_o ( acc_qready_o    ),
    .data_i  ( acc_qreq_i      ),
    .valid_o ( acc_req_q_valid ),
    .ready_i ( acc_req_q_ready ),
    .data_o  ( acc_req_q       )
  );

  shared_muldiv i_shared_muldiv (
    .clk_i        ( clk_i            ),
    .rst_i        ( rst_i            ),
    .req_i        ( acc_req_q        ),
    .req_valid_i  ( acc_req_q_valid  ),
    .req_ready_o  ( acc_req_q_ready  ),
    .resp_o       ( acc_resp_d       ),
    .resp_valid_o ( acc_resp_d_valid ),
    .resp_ready_i ( acc_resp_d_ready )
  );

  // Cut the response path
  spill_register #(
    .T      ( acc_resp_t     ),
    .Bypass ( !`CC_REG_RESP  )
  ) i_spill_register_acc_resp (
    .clk_i   ( clk_i            ),
    .rst_i   ( rst_i            ),
    .valid_i ( acc_resp_d_valid ),
    .ready_o ( acc_resp_d_ready ),
    .data_i  ( acc_resp_d       ),
    .valid_o ( acc_pvalid_o     ),
    .ready_i ( acc_pready_i     ),
    .data_o  ( acc_presp_o      )
  );

endmodule

// ==== src/shared_muldiv.sv ====
`timescale 1ns/1ns

module shared_muldiv import offload_cc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  acc_req_t  req_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  output acc_resp_t resp_o,
  output logic      resp_valid_o,
  input  logic      resp_ready_i
);

  muldiv_dec_t dec;
  logic        dec_valid, dec_ready;
  acc_resp_t   exe;
  logic        exe_valid, exe_ready;

  muldiv_decode i_decode (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .req_i       ( req_i       ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .dec_o       ( dec         ),
    .dec_valid_o ( dec_valid   ),
    .dec_ready_i ( dec_ready   )
  );

  // One operation at a time, divisions stall the decode stage
  muldiv_execute i_execute (
    .clk_i        ( clk_i     ),
    .rst_i        ( rst_i     ),
    .dec_i        ( dec       ),
    .dec_valid_i  ( dec_valid ),
    .dec_ready_o  ( dec_ready ),
    .resp_o       ( exe       ),
    .resp_valid_o ( exe_valid ),
    .resp_ready_i ( exe_ready )
  );

  muldiv_result i_result (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .resp_i       ( exe          ),
    .resp_valid_i ( exe_valid    ),
    .resp_ready_o ( exe_ready    ),
    .resp_o       ( resp_o       ),
    .resp_valid_o ( resp_valid_o ),
    .resp_ready_i ( resp_ready_i )
  );

endmodule

// ==== src/muldiv_result.sv ====
`timescale 1ns/1ns

module muldiv_result import offload_cc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  acc_resp_t resp_i,
  input  logic      resp_valid_i,
  output logic      resp_ready_o,
  output acc_resp_t resp_o,
  output logic      resp_valid_o,
  input  logic      resp_ready_i
);

  logic load;

  // ------------------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------------------

  // Free when empty or when the held response leaves this cycle
  assign resp_ready_o = !resp_valid_o || resp_ready_i;
  assign load         = resp_valid_i && resp_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_o <= 1'b0;
    end else if (load) begin
      resp_valid_o <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      resp_o <= resp_i;
    end
  end

  // Consumer side sees a held response until it takes it
  assert property (@(posedge clk_i) disable iff (rst_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o));

endmodule

// ==== src/muldiv_execute.sv ====
`timescale 1ns/1ns
`include "offload_cc_cfg.svh"

module muldiv_execute import offload_cc_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  muldiv_dec_t dec_i,
  input  logic        dec_valid_i,
  output logic        dec_ready_o,
  output acc_resp_t   resp_o,
  output logic        resp_valid_o,
  input  logic        resp_ready_i
);

  localparam int DataW = `CC_DATA_W;
  localparam int CntW  = $clog2(DataW + 1);

  typedef enum logic [1:0] {IDLE, DIVIDE, DONE} exe_state_e;

  exe_state_e      state_q;
  logic [CntW-1:0] cnt_q;
  logic            accept;

  // Multiplier
  logic signed [DataW:0]     mul_a, mul_b;
  logic signed [2*DataW+1:0] product;
  data_t                     mul_result;

  // Divider, operation held for the whole iteration
  muldiv_dec_t    div_op_q;
  data_t          quo_q, rem_q, dvs_q;
  logic [DataW:0] rem_shift, rem_diff;
  data_t          quo_next, rem_next;
  logic           neg_a, neg_b, div_zero, div_ovf;
  data_t          quo_fixed, rem_fixed, div_result;

  assign dec_ready_o  = (state_q == IDLE) || (state_q == DONE && resp_ready_i);
  assign accept       = dec_valid_i && dec_ready_o;
  assign resp_valid_o = (state_q == DONE);

  // ------------------------------------------------------------------------
  // Single-cycle multiplier
  // ------------------------------------------------------------------------
  assign mul_a      = {dec_i.signed_a && dec_i.arga[DataW-1], dec_i.arga};
  assign mul_b      = {dec_i.signed_b && dec_i.argb[DataW-1], dec_i.argb};
  assign product    = mul_a * mul_b;
  assign mul_result = dec_i.high_part ? product[2*DataW-1:DataW] : product[DataW-1:0];

  // ------------------------------------------------------------------------
  // Restoring divider step and sign fix
  // ------------------------------------------------------------------------
  assign neg_a = div_op_q.signed_a && div_op_q.arga[DataW-1];
  assign neg_b = div_op_q.signed_b && div_op_q.argb[DataW-1];

  assign rem_shift = {rem_q, quo_q[DataW-1]};
  assign rem_diff  = rem_shift - {1'b0, dvs_q};
  // Top bit set means the subtraction went negative, so restore
  assign quo_next  = {quo_q[DataW-2:0], !rem_diff[DataW]};
  assign rem_next  = rem_diff[DataW] ? rem_shift[DataW-1:0] : rem_diff[DataW-1:0];

  assign quo_fixed = (neg_a ^ neg_b) ? -quo_next : quo_next;
  assign rem_fixed = neg_a ? -rem_next : rem_next;

  assign div_zero = (div_op_q.argb == '0);
  assign div_ovf  = div_op_q.signed_a && (div_op_q.arga == {1'b1, {(DataW-1){1'b0}}})
                    && (div_op_q.argb == '1);

  always_comb begin
    if (div_zero) begin
      div_result = div_op_q.is_rem ? div_op_q.arga : '1;
    end else if (div_ovf) begin
      div_result = div_op_q.is_rem ? '0 : div_op_q.arga;
    end else begin
      div_result = div_op_q.is_rem ? rem_fixed : quo_fixed;
    end
  end

  // ------------------------------------------------------------------------
  // Control FSM
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE, DONE: begin
          if (accept) begin
            state_q <= dec_i.is_div ? DIVIDE : DONE;
            cnt_q   <= '0;
          end else if (state_q == DONE && resp_ready_i) begin
            state_q <= IDLE;
          end
        end
        // Count 0 is the setup cycle, counts 1 to DataW are the steps
        DIVIDE: begin
          if (cnt_q == CntW'(DataW)) begin
            state_q <= DONE;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge clk_i) begin
    if (accept) begin
      div_op_q      <= dec_i;
      resp_o.id     <= dec_i.id;
      resp_o.error  <= dec_i.illegal;
      resp_o.data   <= dec_i.illegal ? '0 : mul_result;
    end
    if (state_q == DIVIDE) begin
      if (cnt_q == '0) begin
        quo_q <= neg_a ? -div_op_q.arga : div_op_q.arga;
        dvs_q <= neg_b ? -div_op_q.argb : div_op_q.argb;
        rem_q <= '0;
      end else begin
        quo_q <= quo_next;
        rem_q <= rem_next;
      end
      if (cnt_q == CntW'(DataW)) begin
        resp_o.data <= div_result;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i) cnt_q <= CntW'(DataW));

endmodule

// ==== src/muldiv_decode.sv ====
`timescale 1ns/1ns

module muldiv_decode import offload_cc_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  acc_req_t    req_i,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  output muldiv_dec_t dec_o,
  output logic        dec_valid_o,
  input  logic        dec_ready_i
);

  muldiv_op_e  op;
  muldiv_dec_t dec_d;

  assign op = muldiv_op_e'(req_i.op);

  // ------------------------------------------------------------------------
  // Operation classification
  // ------------------------------------------------------------------------
  always_comb begin
    dec_d      = '0;
    dec_d.id   = req_i.id;
    dec_d.arga = req_i.arga;
    dec_d.argb = req_i.argb;
    case (op)
      OP_MUL: begin
        dec_d.high_part = 1'b0;
      end
      OP_MULH: begin
        dec_d.high_part = 1'b1;
        dec_d.signed_a  = 1'b1;
        dec_d.signed_b  = 1'b1;
      end
      OP_MULHSU: begin
        dec_d.high_part = 1'b1;
        dec_d.signed_a  = 1'b1;
      end
      OP_MULHU: begin
        dec_d.high_part = 1'b1;
      end
      // Remainders run through the divider too
      OP_DIV, OP_REM: begin
        dec_d.is_div   = 1'b1;
        dec_d.is_rem   = (op == OP_REM);
        dec_d.signed_a = 1'b1;
        dec_d.signed_b = 1'b1;
      end
      OP_DIVU, OP_REMU: begin
        dec_d.is_div = 1'b1;
        dec_d.is_rem = (op == OP_REMU);
      end
      default: begin
        dec_d.illegal = 1'b1;
      end
    endcase
  end

  // ------------------------------------------------------------------------
  // Pipeline register
  // ------------------------------------------------------------------------
  assign req_ready_o = !dec_valid_o || dec_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dec_valid_o <= 1'b0;
    end else if (req_ready_o) begin
      dec_valid_o <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      dec_o <= dec_d;
    end
  end

endmodule

// ==== src/spill_register.sv ====
`timescale 1ns/1ns

module spill_register #(
  parameter type T      = logic,
  parameter bit  Bypass = 1'b0
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    // Slot a takes every input, slot b only catches a stalled item
    logic a_full_q, b_full_q;
    T     a_data_q, b_data_q;
    logic a_fill, a_drain;
    logic b_fill, b_drain;

    assign a_fill  = valid_i && ready_o;
    // Slot a empties each cycle, to the output or into slot b
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // Ready comes from registered state only
    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    // Slot b holds the older item whenever it is full
    assign data_o  = b_full_q ? b_data_q : a_data_q;

    // A stalled output keeps its payload
    assert property (@(posedge clk_i) disable iff (rst_i)
      valid_o && !ready_i |=> valid_o && $stable(data_o));
  end

endmodule

// ==== src/offload_cc_pkg.sv ====
package offload_cc_pkg;

  `include "offload_cc_cfg.svh"

  // Widths with a meaning
  typedef logic [`CC_DATA_W-1:0] data_t;
  typedef logic [`CC_ID_W-1:0] id_t;

  // M-extension operations, codes 8 to 15 are illegal
  typedef enum logic [3:0] {
    OP_MUL    = 4'd0,
    OP_MULH   = 4'd1,
    OP_MULHSU = 4'd2,
    OP_MULHU  = 4'd3,
    OP_DIV    = 4'd4,
    OP_DIVU   = 4'd5,
    OP_REM    = 4'd6,
    OP_REMU   = 4'd7
  } muldiv_op_e;

  // Offload request from the core
  typedef struct packed {
    logic [3:0] op;
    id_t        id;
    data_t      arga;
    data_t      argb;
  } acc_req_t;

  // Offload response back to the core
  typedef struct packed {
    id_t   id;
    data_t data;
    logic  error;
  } acc_resp_t;

  // Decoded operation handed to the execute stage
  typedef struct packed {
    id_t   id;
    data_t arga;
    data_t argb;
    logic  is_div;
    logic  is_rem;
    logic  high_part;
    logic  signed_a;
    logic  signed_b;
    logic  illegal;
  } muldiv_dec_t;

endpackage

// ==== src/offload_cc_cfg.svh ====
`ifndef OFFLOAD_CC_CFG_SVH
`define OFFLOAD_CC_CFG_SVH

// ------------------------------------------------------------------------
// Offload slice configuration
// ------------------------------------------------------------------------

// Operand and result width
`define CC_DATA_W 32

// Destination register tag, wide enough for 32 integer registers
`define CC_ID_W 5

// Spill register enables on the offload port
// 1 cuts the path with a two-entry register, 0 passes it straight through
`define CC_REG_REQ 1
`define CC_REG_RESP 1

`endif
